// File: Makefile
# Verilator build and run of the sound board bus testbench
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := snd_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := RESULT: FAIL

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
+incdir+hw
hw/snd_bus_pkg.sv
hw/snd_ctl_pkg.sv
hw/snd_bus_if.sv
hw/snd_cycle_timer.sv
hw/snd_cycle_fsm.sv
hw/snd_io_decode.sv
hw/snd_work_ram.sv
hw/snd_bus_top.sv
tests/snd_tb_assert.sv
tests/snd_tb.sv

// File: hw/snd_bus_if.sv
// Decoded bus cycle shared by the cycle controller, the decoder and the work RAM
// The decoder owns the cycle contents, the controller owns the enable
`timescale 1ns/1ps
`default_nettype none

interface snd_bus_if;

    // Cycle contents, held from strobe to enable
    snd_bus_pkg::cpu_addr_t   addr;
    snd_bus_pkg::cpu_data_t   wdata;
    logic                     wrn;
    snd_bus_pkg::snd_region_e region;
    // High while a cycle is in progress
    logic                     sel_valid;
    // Single cycle-end pulse
    logic                     ce;

    modport decode (
        output addr, wdata, wrn, region, sel_valid,
        input  ce
    );

    modport ctrl (
        input  region, sel_valid,
        output ce
    );

    modport mem (
        input addr, wdata, wrn, region, sel_valid, ce
    );

endinterface

`default_nettype wire

// File: hw/snd_bus_pkg.sv
// Bus level types of the sound CPU: address, data, ROM and RAM offsets, region codes
// Referenced by scoped names from the decoder, RAM, interface and top level
`default_nettype none

`include "snd_consts.svh"

package snd_bus_pkg;

    // Full CPU address as seen on the bus
    typedef logic [`SND_ADDR_W-1:0] cpu_addr_t;

    // One data byte, both directions
    typedef logic [`SND_DATA_W-1:0] cpu_data_t;

    // Address presented to the program ROM
    typedef logic [`SND_ROM_AW-1:0] rom_addr_t;

    // Byte offset inside work RAM
    typedef logic [`SND_RAM_AW-1:0] ram_addr_t;

    // Decoded region of one bus cycle
    typedef enum logic [2:0] {
        REG_NONE,
        REG_ROM,
        REG_RAM,
        REG_OPL,
        REG_OPN,
        REG_OKI,
        REG_LATCH
    } snd_region_e;

endpackage

`default_nettype wire

// File: hw/snd_bus_top.sv
// Sound board bus side: cycle controller, timer, decoder and work RAM on plain ports
// The sound CPU, ROM and sound chips sit outside and connect here
`timescale 1ns/1ps
`default_nettype none

module snd_bus_top (
    input  wire logic                     clk,
    input  wire logic                     arst_n,
    // Sound CPU
    input  wire logic                     cpu_sx,
    input  wire snd_bus_pkg::cpu_addr_t   cpu_addr,
    input  wire snd_bus_pkg::cpu_data_t   cpu_dout,
    input  wire logic                     cpu_wrn,
    input  wire logic                     cpu_rdn,
    output logic                          cpu_ce,
    output snd_bus_pkg::cpu_data_t        cpu_din,
    output logic                          cpu_wait_n,
    output logic                          irqn,
    // Main CPU command
    input  wire logic                     snreq,
    input  wire snd_bus_pkg::cpu_data_t   latch,
    // Program ROM
    output snd_bus_pkg::rom_addr_t        rom_addr,
    output logic                          rom_cs,
    input  wire snd_bus_pkg::cpu_data_t   rom_data,
    input  wire logic                     rom_ok,
    // Sound chips
    output logic                          opl_cs,
    output logic                          opn_cs,
    output logic                          oki_cs,
    output logic                          chip_a0,
    output logic                          chip_wrn,
    output snd_bus_pkg::cpu_data_t        chip_wdata,
    input  wire snd_bus_pkg::cpu_data_t   opl_dout,
    input  wire snd_bus_pkg::cpu_data_t   opn_dout,
    input  wire snd_bus_pkg::cpu_data_t   oki_dout,
    input  wire logic                     opl_irqn,
    input  wire logic                     opn_irqn
);

    snd_bus_if              bus ();
    logic                   tmr_start;
    logic                   tmr_done;
    logic                   latch_irq;
    snd_bus_pkg::cpu_data_t ram_q;

    snd_cycle_fsm u_fsm (
        .clk       ( clk        ),
        .arst_n    ( arst_n     ),
        .sx        ( cpu_sx     ),
        .rom_ok    ( rom_ok     ),
        .bus       ( bus.ctrl   ),
        .tmr_start ( tmr_start  ),
        .tmr_done  ( tmr_done   ),
        .wait_n    ( cpu_wait_n )
    );

    snd_cycle_timer u_timer (
        .clk    ( clk       ),
        .arst_n ( arst_n    ),
        .start  ( tmr_start ),
        .done   ( tmr_done  )
    );

    snd_io_decode u_decode (
        .clk       ( clk        ),
        .arst_n    ( arst_n     ),
        .sx        ( cpu_sx     ),
        .addr      ( cpu_addr   ),
        .dout      ( cpu_dout   ),
        .wrn       ( cpu_wrn    ),
        .rdn       ( cpu_rdn    ),
        .bus       ( bus.decode ),
        .ram_q     ( ram_q      ),
        .rom_data  ( rom_data   ),
        .opl_dout  ( opl_dout   ),
        .opn_dout  ( opn_dout   ),
        .oki_dout  ( oki_dout   ),
        .snreq     ( snreq      ),
        .latch     ( latch      ),
        .rom_cs    ( rom_cs     ),
        .opl_cs    ( opl_cs     ),
        .opn_cs    ( opn_cs     ),
        .oki_cs    ( oki_cs     ),
        .din       ( cpu_din    ),
        .latch_irq ( latch_irq  )
    );

    snd_work_ram u_ram (
        .clk ( clk     ),
        .bus ( bus.mem ),
        .q   ( ram_q   )
    );

    assign cpu_ce     = bus.ce;
    // ROM and chips see the held address, not the live CPU bus
    assign rom_addr   = bus.addr[15:0];
    assign chip_a0    = bus.addr[0];
    assign chip_wrn   = bus.wrn;
    assign chip_wdata = bus.wdata;
    // Any pending source pulls the CPU interrupt low
    assign irqn       = opl_irqn & opn_irqn & ~latch_irq;

endmodule

`default_nettype wire

// File: hw/snd_consts.svh
// Fixed constants of the sound board bus: address map widths, RAM depth and cycle timing
// Include wherever a width or the strobe-to-enable distance is needed
`ifndef SND_CONSTS_SVH
`define SND_CONSTS_SVH

// CPU address bus, 2 MB linear space
`define SND_ADDR_W 21

// CPU data bus
`define SND_DATA_W 8

// Program ROM window, lower 64 KB of the CPU space
`define SND_ROM_AW 16

// Work RAM offset bits, 8 KB
`define SND_RAM_AW 13

// Clock cycles from the strobe to the earliest cycle-end enable
`define SND_SX_TO_CE 3

// Read value for addresses that hit no region
`define SND_UNMAPPED 8'hFF

`endif

// File: hw/snd_ctl_pkg.sv
// Types of the bus cycle controller and its setup timer
`default_nettype none

package snd_ctl_pkg;

    // One bus cycle: setup, optional ROM wait, then the enable
    typedef enum logic [1:0] {
        CYC_IDLE,
        CYC_SETUP,
        CYC_WAIT,
        CYC_END
    } cyc_state_e;

    // Setup counter, enough for the strobe-to-enable distance
    typedef logic [1:0] cyc_count_t;

endpackage

`default_nettype wire

// File: hw/snd_cycle_fsm.sv
// Bus cycle controller: runs one cycle from the strobe to the cycle-end enable
// Stretches ROM cycles with wait_n until the ROM reports its data
`timescale 1ns/1ps
`default_nettype none

module snd_cycle_fsm (
    input  wire logic   clk,
    input  wire logic   arst_n,
    input  wire logic   sx,
    input  wire logic   rom_ok,
    snd_bus_if.ctrl     bus,
    output logic        tmr_start,
    input  wire logic   tmr_done,
    output logic        wait_n
);

    snd_ctl_pkg::cyc_state_e state;
    snd_ctl_pkg::cyc_state_e state_nx;
    logic                    rom_ok_q;
    logic                    rom_cycle;

    assign rom_cycle = bus.sel_valid && (bus.region == snd_bus_pkg::REG_ROM);

    // ROM ready, sampled once and only for a ROM cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rom_ok_q <= 1'b0;
        end else begin
            rom_ok_q <= rom_ok && rom_cycle;
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            snd_ctl_pkg::CYC_IDLE: begin
                // New strobes only count here, busy strobes are dropped
                if (sx) begin
                    state_nx = snd_ctl_pkg::CYC_SETUP;
                end
            end
            snd_ctl_pkg::CYC_SETUP: begin
                if (tmr_done) begin
                    if (rom_cycle && !rom_ok_q) begin
                        state_nx = snd_ctl_pkg::CYC_WAIT;
                    end else begin
                        state_nx = snd_ctl_pkg::CYC_END;
                    end
                end
            end
            snd_ctl_pkg::CYC_WAIT: begin
                // No time limit, the ROM decides
                if (rom_ok_q) begin
                    state_nx = snd_ctl_pkg::CYC_END;
                end
            end
            default: begin
                state_nx = snd_ctl_pkg::CYC_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= snd_ctl_pkg::CYC_IDLE;
        end else begin
            state <= state_nx;
        end
    end

    // Timer runs off the accepted strobe
    assign tmr_start = (state == snd_ctl_pkg::CYC_IDLE) && sx;
    // Enable lasts exactly the END state
    assign bus.ce    = (state == snd_ctl_pkg::CYC_END);
    assign wait_n    = (state != snd_ctl_pkg::CYC_WAIT);

endmodule

`default_nettype wire

// File: hw/snd_cycle_timer.sv
// Setup timer between the strobe and the earliest cycle-end enable
// Restarted by the controller on every accepted strobe
`timescale 1ns/1ps
`default_nettype none

`include "snd_consts.svh"

module snd_cycle_timer (
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire logic start,
    output logic      done
);

    snd_ctl_pkg::cyc_count_t cnt;

    // The strobe cycle itself is the first setup cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (start) begin
            cnt <= snd_ctl_pkg::cyc_count_t'(`SND_SX_TO_CE - 1);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    // Last counted cycle, controller moves to the enable on the next edge
    assign done = (cnt == snd_ctl_pkg::cyc_count_t'(1));

endmodule

`default_nettype wire

// File: hw/snd_io_decode.sv
// Address decoder of the sound CPU with held selects, sound latch and read data mux
// Captures the cycle at the strobe and releases it after the cycle-end enable
`timescale 1ns/1ps
`default_nettype none

`include "snd_consts.svh"

module snd_io_decode (
    input  wire logic                      clk,
    input  wire logic                      arst_n,
    input  wire logic                      sx,
    input  wire snd_bus_pkg::cpu_addr_t    addr,
    input  wire snd_bus_pkg::cpu_data_t    dout,
    input  wire logic                      wrn,
    input  wire logic                      rdn,
    snd_bus_if.decode                      bus,
    input  wire snd_bus_pkg::cpu_data_t    ram_q,
    input  wire snd_bus_pkg::cpu_data_t    rom_data,
    input  wire snd_bus_pkg::cpu_data_t    opl_dout,
    input  wire snd_bus_pkg::cpu_data_t    opn_dout,
    input  wire snd_bus_pkg::cpu_data_t    oki_dout,
    input  wire logic                      snreq,
    input  wire snd_bus_pkg::cpu_data_t    latch,
    output logic                           rom_cs,
    output logic                           opl_cs,
    output logic                           opn_cs,
    output logic                           oki_cs,
    output snd_bus_pkg::cpu_data_t         din,
    output logic                           latch_irq
);

    snd_bus_pkg::cpu_data_t latch_q;

    // Fixed map, ROM first, then A[17:15] in the upper megabyte
    function automatic snd_bus_pkg::snd_region_e region_of(input snd_bus_pkg::cpu_addr_t a);
        snd_bus_pkg::snd_region_e r;
        if (!a[`SND_ADDR_W-1]) begin
            r = snd_bus_pkg::REG_ROM;
        end else begin
            case (a[17:15])
                3'b001:  r = snd_bus_pkg::REG_OPL;
                3'b011:  r = snd_bus_pkg::REG_OPN;
                3'b100:  r = snd_bus_pkg::REG_OKI;
                3'b110:  r = snd_bus_pkg::REG_LATCH;
                3'b111:  r = snd_bus_pkg::REG_RAM;
                default: r = snd_bus_pkg::REG_NONE;
            endcase
        end
        return r;
    endfunction

    // Control side of the held cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bus.region    <= snd_bus_pkg::REG_NONE;
            bus.sel_valid <= 1'b0;
            bus.wrn       <= 1'b1;
        end else if (bus.ce) begin
            bus.region    <= snd_bus_pkg::REG_NONE;
            bus.sel_valid <= 1'b0;
            bus.wrn       <= 1'b1;
        end else if (sx && !bus.sel_valid) begin
            bus.region    <= region_of(addr);
            bus.sel_valid <= 1'b1;
            bus.wrn       <= wrn;
        end
    end

    // Address and write data only matter while sel_valid is high
    always_ff @(posedge clk) begin
        if (sx && !bus.sel_valid) begin
            bus.addr  <= addr;
            bus.wdata <= dout;
        end
    end

    // Sound command from the main CPU, a new command wins over a read clear
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            latch_q   <= '0;
            latch_irq <= 1'b0;
        end else if (snreq) begin
            latch_q   <= latch;
            latch_irq <= 1'b1;
        end else if (bus.ce && bus.region == snd_bus_pkg::REG_LATCH && !rdn) begin
            latch_irq <= 1'b0;
        end
    end

    assign rom_cs = bus.sel_valid && (bus.region == snd_bus_pkg::REG_ROM);
    assign opl_cs = bus.sel_valid && (bus.region == snd_bus_pkg::REG_OPL);
    assign opn_cs = bus.sel_valid && (bus.region == snd_bus_pkg::REG_OPN);
    assign oki_cs = bus.sel_valid && (bus.region == snd_bus_pkg::REG_OKI);

    // Read data one cycle behind its source, ready by the enable
    always_ff @(posedge clk) begin
        case (bus.region)
            snd_bus_pkg::REG_ROM:   din <= rom_data;
            snd_bus_pkg::REG_RAM:   din <= ram_q;
            snd_bus_pkg::REG_OPL:   din <= opl_dout;
            snd_bus_pkg::REG_OPN:   din <= opn_dout;
            snd_bus_pkg::REG_OKI:   din <= oki_dout;
            snd_bus_pkg::REG_LATCH: din <= latch_q;
            default:                din <= `SND_UNMAPPED;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/snd_work_ram.sv
// 8 KB work RAM of the sound CPU, written at the cycle-end enable
// Read data follows the held offset one clock later
`timescale 1ns/1ps
`default_nettype none

`include "snd_consts.svh"

module snd_work_ram (
    input  wire logic               clk,
    snd_bus_if.mem                  bus,
    output snd_bus_pkg::cpu_data_t  q
);

    snd_bus_pkg::cpu_data_t mem [0:(1 << `SND_RAM_AW)-1];
    snd_bus_pkg::ram_addr_t offset;
    logic                   we;

    // Offset is A[12:0] of the held address
    assign offset = bus.addr[`SND_RAM_AW-1:0];
    assign we     = bus.ce && bus.sel_valid && !bus.wrn
                    && (bus.region == snd_bus_pkg::REG_RAM);

    always_ff @(posedge clk) begin
        if (we) begin
            mem[offset] <= bus.wdata;
        end
        // Read first, a write shows up on the next access
        q <= mem[offset];
    end

endmodule

`default_nettype wire

// File: tests/snd_stim.txt
// op addr data delay, hex; op 0 read, 1 write, 2 main CPU command
// op 3 RAM fill with generated byte, 4 RAM check, F end of stimulus
// Chip reads and writes
0 108000 0A 0
0 118001 0B 0
0 120000 0C 0
1 108001 3F 0
1 118000 77 0
1 120001 81 0
// Unmapped space
0 110000 FF 0
0 128000 FF 0
0 100000 FF 0
// Work RAM, first and last offset included
3 138000 00 0
3 139FFF 00 0
3 138123 00 0
1 13A555 C3 0
4 138000 00 0
4 139FFF 00 0
4 138123 00 0
0 13A555 C3 0
// ROM reads with growing delay
0 001234 26 0
0 00ABCD 66 1
0 0F00FF FF 2
0 005A3C 66 3
0 00FFFF 00 4
0 008001 81 5
0 007E42 3C 6
// Sound command and its latch read
2 000000 5C 0
0 130000 5C 0
F 000000 00 0

// File: tests/snd_tb.sv
// Testbench of the sound board bus that acts as sound CPU, ROM, sound chips and main CPU
// Runs the operations of tests/snd_stim.txt and checks data, selects, timing and interrupt
`timescale 1ns/1ps
`default_nettype none

`include "snd_consts.svh"

module snd_tb;

    localparam int STIM_OPS = 64;

    logic                    clk = 1'b0;
    logic                    arst_n = 1'b0;
    logic                    cpu_sx;
    snd_bus_pkg::cpu_addr_t  cpu_addr;
    snd_bus_pkg::cpu_data_t  cpu_dout;
    logic                    cpu_wrn;
    logic                    cpu_rdn;
    logic                    cpu_ce;
    snd_bus_pkg::cpu_data_t  cpu_din;
    logic                    cpu_wait_n;
    logic                    irqn;
    logic                    snreq;
    snd_bus_pkg::cpu_data_t  latch;
    snd_bus_pkg::rom_addr_t  rom_addr;
    logic                    rom_cs;
    snd_bus_pkg::cpu_data_t  rom_data;
    logic                    rom_ok = 1'b0;
    logic                    opl_cs;
    logic                    opn_cs;
    logic                    oki_cs;
    logic                    chip_a0;
    logic                    chip_wrn;
    snd_bus_pkg::cpu_data_t  chip_wdata;

    // Four words per operation in opcode, address, data and ROM delay order
    logic [23:0] stim [0:4*STIM_OPS-1];
    logic [7:0]  ram_model [0:(1 << `SND_RAM_AW)-1];
    logic [31:0] lcg_state;
    int          rom_delay = 0;
    int          rom_cnt = 0;
    bit          irq_pending;
    bit          wd_armed = 1'b0;
    int          wd_cycles;
    string       test_name;

    snd_bus_top DUT (
        .clk(clk), .arst_n(arst_n),
        .cpu_sx(cpu_sx), .cpu_addr(cpu_addr), .cpu_dout(cpu_dout),
        .cpu_wrn(cpu_wrn), .cpu_rdn(cpu_rdn), .cpu_ce(cpu_ce),
        .cpu_din(cpu_din), .cpu_wait_n(cpu_wait_n), .irqn(irqn),
        .snreq(snreq), .latch(latch),
        .rom_addr(rom_addr), .rom_cs(rom_cs), .rom_data(rom_data), .rom_ok(rom_ok),
        .opl_cs(opl_cs), .opn_cs(opn_cs), .oki_cs(oki_cs),
        .chip_a0(chip_a0), .chip_wrn(chip_wrn), .chip_wdata(chip_wdata),
        .opl_dout(8'h0A), .opn_dout(8'h0B), .oki_dout(8'h0C),
        .opl_irqn(1'b1), .opn_irqn(1'b1)
    );

    always #4 clk = ~clk;

    // ROM data is the low address byte XOR the high address byte
    assign rom_data = rom_addr[7:0] ^ rom_addr[15:8];

    // rom_ok rises rom_delay cycles after rom_cs and drops with it
    always @(posedge clk) begin
        #1;
        if (!rom_cs) begin
            rom_cnt = 0;
            rom_ok  = 1'b0;
        end else begin
            if (rom_cnt >= rom_delay) begin
                rom_ok = 1'b1;
            end
            rom_cnt = rom_cnt + 1;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Expected {rom, opl, opn, oki} selects from the address map
    function automatic logic [3:0] expected_sel(input snd_bus_pkg::cpu_addr_t a);
        logic [3:0] s;
        s = 4'b0000;
        if (!a[20]) begin
            s = 4'b1000;
        end else begin
            case (a[17:15])
                3'b001:  s = 4'b0100;
                3'b011:  s = 4'b0010;
                3'b100:  s = 4'b0001;
                default: s = 4'b0000;
            endcase
        end
        return s;
    endfunction

    task automatic value_error(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        $display("ERROR %s: %s expected %0h actual %0h", test_name, what, exp, act);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic abort_run(input string msg);
        $display("ERROR %s: %s", test_name, msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else value_error(what, exp, act);
    endtask

    // One CPU bus cycle from the strobe through the cycle after cpu_ce
    task automatic bus_cycle(input bit write, input snd_bus_pkg::cpu_addr_t addr,
                             input logic [7:0] data, input int delay);
        int         cyc;
        int         waits;
        int         exp_waits;
        logic [3:0] sel;
        sel       = expected_sel(addr);
        exp_waits = sel[3] ? delay : 0;
        rom_delay = delay;
        cpu_addr  = addr;
        cpu_dout  = data;
        cpu_wrn   = !write;
        cpu_rdn   = write;
        cpu_sx    = 1'b1;
        @(posedge clk);
        #1;
        cpu_sx = 1'b0;
        cyc    = 1;
        waits  = 0;
        while (!cpu_ce && cyc < 16 + delay) begin
            // Selects stay up for the whole cycle
            check_eq("selects held", sel, {rom_cs, opl_cs, opn_cs, oki_cs});
            if (!cpu_wait_n) begin
                waits++;
            end
            @(posedge clk);
            #1;
            cyc++;
        end
        assert (cpu_ce) else abort_run("cpu_ce did not arrive within the cycle limit");
        check_eq("enable cycle", `SND_SX_TO_CE + exp_waits, cyc);
        check_eq("wait cycles", exp_waits, waits);
        check_eq("selects", sel, {rom_cs, opl_cs, opn_cs, oki_cs});
        if (sel[3]) begin
            check_eq("rom_addr", addr[`SND_ROM_AW-1:0], rom_addr);
        end
        if (write) begin
            check_eq("chip_wdata", data, chip_wdata);
            check_eq("chip_a0", addr[0], chip_a0);
            check_eq("chip_wrn", 0, chip_wrn);
        end else begin
            check_eq("read data", data, cpu_din);
            check_eq("chip_wrn", 1, chip_wrn);
        end
        @(posedge clk);
        #1;
        cpu_wrn = 1'b1;
        cpu_rdn = 1'b1;
        check_eq("selects after enable", 0, {rom_cs, opl_cs, opn_cs, oki_cs});
    endtask

    // Main CPU writes a sound command
    task automatic main_cpu_command(input logic [7:0] data);
        snreq = 1'b1;
        latch = data;
        @(posedge clk);
        #1;
        snreq = 1'b0;
        irq_pending = 1'b1;
    endtask

    // Run limit from the stim length and armed once the file is read
    initial begin
        wait (wd_armed);
        repeat (wd_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run hung", wd_cycles);
        $display("RESULT: FAIL");
        $fatal(1);
    end

    initial begin
        int                     n_ops;
        int                     max_delay;
        logic [23:0]            op;
        snd_bus_pkg::cpu_addr_t addr;
        logic [7:0]             data;
        logic [7:0]             fill;
        cpu_sx      = 1'b0;
        cpu_addr    = '0;
        cpu_dout    = '0;
        cpu_wrn     = 1'b1;
        cpu_rdn     = 1'b1;
        snreq       = 1'b0;
        latch       = '0;
        lcg_state   = 32'd73;
        irq_pending = 1'b0;
        test_name   = "stim load";
        $readmemh("tests/snd_stim.txt", stim);
        n_ops     = 0;
        max_delay = 0;
        while (n_ops < STIM_OPS && stim[4*n_ops] != 24'hF) begin
            if (int'(stim[4*n_ops+3]) > max_delay) begin
                max_delay = int'(stim[4*n_ops+3]);
            end
            n_ops++;
        end
        assert (n_ops < STIM_OPS) else abort_run("stim file has no end marker");
        wd_cycles = 64 * n_ops + max_delay;
        wd_armed  = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        // Idle bus straight out of reset
        test_name = "reset";
        check_eq("cpu_ce", 0, cpu_ce);
        check_eq("cpu_wait_n", 1, cpu_wait_n);
        check_eq("selects", 0, {rom_cs, opl_cs, opn_cs, oki_cs});
        check_eq("irqn", 1, irqn);
        for (int i = 0; i < n_ops; i++) begin
            op        = stim[4*i];
            addr      = stim[4*i+1][`SND_ADDR_W-1:0];
            data      = stim[4*i+2][7:0];
            test_name = $sformatf("op %0d type %0h addr %06h", i, op, addr);
            case (op)
                24'h0: bus_cycle(1'b0, addr, data, int'(stim[4*i+3]));
                24'h1: bus_cycle(1'b1, addr, data, 0);
                24'h2: main_cpu_command(data);
                24'h3: begin
                    lcg_state = lcg_next(lcg_state);
                    fill      = lcg_state[23:16];
                    ram_model[addr[`SND_RAM_AW-1:0]] = fill;
                    bus_cycle(1'b1, addr, fill, 0);
                end
                24'h4: bus_cycle(1'b0, addr, ram_model[addr[`SND_RAM_AW-1:0]], 0);
                default: abort_run("unknown opcode in stim file");
            endcase
            // Latch read acknowledges the sound interrupt
            if (op == 24'h0 && addr[20] && addr[17:15] == 3'b110) begin
                irq_pending = 1'b0;
            end
            check_eq("irqn", !irq_pending, irqn);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/snd_tb_assert.sv
// Bus protocol assertions on the cycle controller
// Bound into every snd_cycle_fsm instance from the bottom of this file
`timescale 1ns/1ps
`default_nettype none

module snd_tb_assert (
    input wire logic                    clk,
    input wire logic                    arst_n,
    input wire logic                    sx,
    input wire logic                    ce,
    input wire logic                    wait_n,
    input wire snd_ctl_pkg::cyc_state_e state
);

    // Cycle-end enable is a single pulse
    ce_single: assert property (@(posedge clk) disable iff (!arst_n)
        ce |=> !ce)
        else $error("cpu_ce stayed high for more than one cycle");

    // Wait only while the ROM is awaited
    wait_in_wait: assert property (@(posedge clk) disable iff (!arst_n)
        !wait_n |-> state == snd_ctl_pkg::CYC_WAIT)
        else $error("wait_n low outside CYC_WAIT");

    // No strobe, no new cycle
    idle_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (state == snd_ctl_pkg::CYC_IDLE && !sx) |=> state == snd_ctl_pkg::CYC_IDLE)
        else $error("controller left CYC_IDLE without a strobe");

endmodule

bind snd_cycle_fsm snd_tb_assert u_assert (
    .clk    ( clk    ),
    .arst_n ( arst_n ),
    .sx     ( sx     ),
    .ce     ( bus.ce ),
    .wait_n ( wait_n ),
    .state  ( state  )
);

`default_nettype wire
